// File: logic/fetchPkg.sv
package fetchPkg;

    // byte address
    typedef logic [31:0] addr_t;

    // full instruction word
    typedef logic [31:0] insn_t;

    // one halfword, the unit the buffer stores
    typedef logic [15:0] half_t;

    localparam int INSN_WIDTH = $bits(insn_t);
    localparam int LINE_WIDTH = 64;

    // words per memory line
    localparam int INSN_PER_LINE = LINE_WIDTH / INSN_WIDTH;

    // byte offset bits inside a word and inside a line
    localparam int INSN_OFFSET_WIDTH = $clog2(INSN_WIDTH / 8);
    localparam int LINE_OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);

    // word 0 sits at the lower address
    typedef insn_t [INSN_PER_LINE-1:0] line_t;

    // one buffered halfword with its own pc
    typedef struct packed {
        addr_t pc;
        logic  fault;
        half_t insn;
    } insnEntry_t;

    // what the aligner can make of the buffer heads
    typedef enum logic [1:0] {
        ALIGN_NONE,
        ALIGN_COMPRESSED,
        ALIGN_FULL,
        ALIGN_FAULT
    } alignKind_t;

endpackage

// File: logic/fetchUnitIf.sv
`timescale 1ns/1ps

interface fetchUnitIf import fetchPkg::*; ();

    // fetch unit side
    addr_t pc;
    line_t iCacheLine;
    logic  valid;
    logic  fault;

    // fetch stage side
    addr_t nextPc;
    logic  flush;
    logic  stall;

    modport FetchUnit (
        output pc, iCacheLine, valid, fault,
        input  nextPc, flush, stall
    );

    modport FetchStage (
        input  pc, iCacheLine, valid, fault,
        output nextPc, flush, stall
    );

endinterface

// File: logic/insnBufferIf.sv
`timescale 1ns/1ps

interface insnWriteIf import fetchPkg::*; #(
    parameter int BufferDepth = 8
) ();
    // room for a count from 0 up to the full depth
    localparam int CountWidth = $clog2(BufferDepth) + 1;

    logic                  writeLow;
    logic                  writeHigh;
    insnEntry_t            writeEntryLow;
    insnEntry_t            writeEntryHigh;
    logic [CountWidth-1:0] writableEntryCount;

    modport FetchStage (
        output writeLow, writeHigh, writeEntryLow, writeEntryHigh,
        input  writableEntryCount
    );

    modport Buffer (
        input  writeLow, writeHigh, writeEntryLow, writeEntryHigh,
        output writableEntryCount
    );

endinterface

interface insnReadIf import fetchPkg::*; #(
    parameter int BufferDepth = 8
) ();
    localparam int CountWidth = $clog2(BufferDepth) + 1;

    // two oldest entries, valid up to count
    insnEntry_t            head0;
    insnEntry_t            head1;
    logic [CountWidth-1:0] count;
    logic                  pop1;
    logic                  pop2;
    logic                  flush;

    modport Buffer (
        output head0, head1, count,
        input  pop1, pop2, flush
    );

    modport Aligner (
        input  head0, head1, count,
        output pop1, pop2, flush
    );

endinterface

// File: logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import fetchPkg::*; #(
    parameter int    MemLines = 16,
    parameter addr_t ResetPc  = '0
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        memWe,
    input  logic [$clog2(MemLines)-1:0] memAddr,
    input  line_t                       memData,
    fetchUnitIf.FetchUnit               fetch
);
    localparam int IndexWidth = $clog2(MemLines);

    // instruction memory, one line per entry
    line_t mem [MemLines];

    addr_t                 pc;
    logic [IndexWidth-1:0] lineIndex;
    logic                  outOfRange;
    logic                  consume;

    // program load port
    // only written while redirect keeps the front end idle
    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memData;
        end
    end

    always_comb begin
        lineIndex = pc[LINE_OFFSET_WIDTH +: IndexWidth];
        // any line index at or past MemLines is outside memory
        outOfRange = (pc >> LINE_OFFSET_WIDTH) >= addr_t'(MemLines);
        consume = fetch.valid && !fetch.stall;
    end

    // combinational read from the registered pc
    always_comb begin
        fetch.pc = pc;
        fetch.fault = outOfRange;
        // faulting fetches return zeros
        if (outOfRange) begin
            fetch.iCacheLine = '0;
        end else begin
            fetch.iCacheLine = mem[lineIndex];
        end
        // nothing offered while the pc is being replaced
        fetch.valid = !fetch.flush;
    end

    // pc update
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (fetch.flush) begin
            // redirect target, may point at the upper halfword
            pc <= fetch.nextPc;
        end else if (consume) begin
            // on to the next word boundary
            // the stage takes one word of the line per fetch
            pc <= {pc[31:INSN_OFFSET_WIDTH] + 1'b1, {INSN_OFFSET_WIDTH{1'b0}}};
        end
    end

endmodule

// File: logic/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import fetchPkg::*; (
    input  logic           clk,
    input  logic           rstN,
    input  logic           ctrlFlush,
    input  addr_t          ctrlNextPc,
    fetchUnitIf.FetchStage fetchUnit,
    insnWriteIf.FetchStage insnBuffer
);
    localparam int IndexWidth = $clog2(INSN_PER_LINE);

    logic                  upperHalf;
    logic [IndexWidth-1:0] wordIndex;
    insn_t                 word;
    addr_t                 wordPc;
    logic                  armed;
    logic                  stall;
    logic                  push;

    // held back for the first cycle out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    always_comb begin
        // pc on the upper halfword, low half already behind us
        upperHalf = fetchUnit.pc[1];
        wordIndex = fetchUnit.pc[INSN_OFFSET_WIDTH +: IndexWidth];
        word = fetchUnit.iCacheLine[wordIndex];
        wordPc = {fetchUnit.pc[31:INSN_OFFSET_WIDTH], {INSN_OFFSET_WIDTH{1'b0}}};
        // a word can need two slots
        stall = !armed || insnBuffer.writableEntryCount < 2;
        push = fetchUnit.valid && !stall;
    end

    // control back to the fetch unit
    always_comb begin
        fetchUnit.nextPc = ctrlNextPc;
        fetchUnit.flush = ctrlFlush;
        fetchUnit.stall = stall;
    end

    // halfword entries, low always ahead of high
    always_comb begin
        insnBuffer.writeLow = push && !upperHalf;
        insnBuffer.writeHigh = push;

        insnBuffer.writeEntryLow.pc = wordPc;
        insnBuffer.writeEntryLow.fault = fetchUnit.fault;
        insnBuffer.writeEntryLow.insn = word[15:0];

        insnBuffer.writeEntryHigh.pc = wordPc + addr_t'(2);
        insnBuffer.writeEntryHigh.fault = fetchUnit.fault;
        insnBuffer.writeEntryHigh.insn = word[31:16];
    end

endmodule

// File: logic/insnBuffer.sv
`timescale 1ns/1ps

module insnBuffer import fetchPkg::*; #(
    parameter int BufferDepth = 8
) (
    input  logic       clk,
    input  logic       rstN,
    insnWriteIf.Buffer wr,
    insnReadIf.Buffer  rd
);
    localparam int PtrWidth   = $clog2(BufferDepth);
    localparam int CountWidth = PtrWidth + 1;

    // circular halfword storage
    insnEntry_t entries [BufferDepth];

    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] used;

    logic [PtrWidth-1:0] highSlot;
    logic [PtrWidth-1:0] nextRd;
    logic [1:0]          pushCount;
    logic [1:0]          popCount;

    always_comb begin
        // high lands one slot behind low when both arrive
        if (wr.writeLow) begin
            highSlot = wrPtr + 1'b1;
        end else begin
            highSlot = wrPtr;
        end
        nextRd = rdPtr + 1'b1;
        pushCount = {1'b0, wr.writeLow} + {1'b0, wr.writeHigh};
        // aligner never raises both pops
        if (rd.pop2) begin
            popCount = 2'd2;
        end else begin
            popCount = {1'b0, rd.pop1};
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (!rd.flush) begin
            if (wr.writeLow) begin
                entries[wrPtr] <= wr.writeEntryLow;
            end
            if (wr.writeHigh) begin
                entries[highSlot] <= wr.writeEntryHigh;
            end
        end
    end

    // pointers and occupancy
    // flush wins over any push or pop in the same cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else if (rd.flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else begin
            wrPtr <= wrPtr + PtrWidth'(pushCount);
            rdPtr <= rdPtr + PtrWidth'(popCount);
            used <= used + CountWidth'(pushCount) - CountWidth'(popCount);
        end
    end

    // read side
    always_comb begin
        rd.head0 = entries[rdPtr];
        // only meaningful once count reaches 2
        rd.head1 = entries[nextRd];
        rd.count = used;
    end

    // free slots for the stage's stall
    always_comb begin
        wr.writableEntryCount = CountWidth'(BufferDepth) - used;
    end

endmodule

// File: logic/insnAligner.sv
`timescale 1ns/1ps

module insnAligner import fetchPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        redirect,
    input  logic        insnReady,
    insnReadIf.Aligner  rd,
    output logic        insnValid,
    output insn_t       insn,
    output addr_t       insnPc,
    output logic        insnCompressed,
    output logic        insnFault
);
    alignKind_t kind;
    logic       outEnable;
    logic       accept;

    // output kept quiet for one cycle after reset or redirect
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outEnable <= 1'b0;
        end else begin
            outEnable <= !redirect;
        end
    end

    // classify the oldest halfword
    always_comb begin
        if (rd.count == '0) begin
            kind = ALIGN_NONE;
        end else if (rd.head0.fault) begin
            kind = ALIGN_FAULT;
        end else if (rd.head0.insn[1:0] != 2'b11) begin
            kind = ALIGN_COMPRESSED;
        end else if (rd.count >= 2) begin
            // both halves present, may straddle a line
            kind = ALIGN_FULL;
        end else begin
            // upper half not fetched yet
            kind = ALIGN_NONE;
        end
    end

    // outputs straight from the heads
    always_comb begin
        insnValid = outEnable && !redirect && kind != ALIGN_NONE;
        insnPc = rd.head0.pc;
        insnFault = kind == ALIGN_FAULT;
        // faults also take a single halfword slot
        insnCompressed = kind == ALIGN_COMPRESSED || kind == ALIGN_FAULT;
        if (kind == ALIGN_FULL) begin
            insn = {rd.head1.insn, rd.head0.insn};
        end else begin
            insn = insn_t'(rd.head0.insn);
        end
    end

    // pops on acceptance only
    always_comb begin
        accept = insnValid && insnReady;
        rd.pop1 = accept && kind != ALIGN_FULL;
        rd.pop2 = accept && kind == ALIGN_FULL;
        // redirect drops everything buffered
        rd.flush = redirect;
    end

endmodule

// File: logic/fetchTop.sv
`timescale 1ns/1ps

module fetchTop import fetchPkg::*; #(
    parameter int    MemLines    = 16,
    parameter int    BufferDepth = 8,
    parameter addr_t ResetPc     = '0
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        memWe,
    input  logic [$clog2(MemLines)-1:0] memAddr,
    input  line_t                       memData,
    input  logic                        redirect,
    input  addr_t                       redirectPc,
    output logic                        insnValid,
    input  logic                        insnReady,
    output insn_t                       insn,
    output addr_t                       insnPc,
    output logic                        insnCompressed,
    output logic                        insnFault
);
    // unit to stage
    fetchUnitIf fetchBus ();

    // stage to buffer, buffer to aligner
    insnWriteIf #(.BufferDepth(BufferDepth)) writeBus ();
    insnReadIf  #(.BufferDepth(BufferDepth)) readBus ();

    fetchUnit #(
        .MemLines (MemLines),
        .ResetPc  (ResetPc)
    ) unit (
        .clk     (clk),
        .rstN    (rstN),
        .memWe   (memWe),
        .memAddr (memAddr),
        .memData (memData),
        .fetch   (fetchBus.FetchUnit)
    );

    // redirect restarts fetch at redirectPc
    fetchStage stage (
        .clk        (clk),
        .rstN       (rstN),
        .ctrlFlush  (redirect),
        .ctrlNextPc (redirectPc),
        .fetchUnit  (fetchBus.FetchStage),
        .insnBuffer (writeBus.FetchStage)
    );

    insnBuffer #(
        .BufferDepth (BufferDepth)
    ) buffer (
        .clk  (clk),
        .rstN (rstN),
        .wr   (writeBus.Buffer),
        .rd   (readBus.Buffer)
    );

    // same redirect also empties the buffer
    insnAligner aligner (
        .clk            (clk),
        .rstN           (rstN),
        .redirect       (redirect),
        .insnReady      (insnReady),
        .rd             (readBus.Aligner),
        .insnValid      (insnValid),
        .insn           (insn),
        .insnPc         (insnPc),
        .insnCompressed (insnCompressed),
        .insnFault      (insnFault)
    );

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod = 5
) (
    output logic clk,
    output logic rstN
);
    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // reset low for two full cycles, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: test/fetchTop_props.sv
`timescale 1ns/1ps

module fetchTopProps import fetchPkg::*; #(
    parameter int BufferDepth = 8
) (
    input logic                              clk,
    input logic                              rstN,
    input logic                              redirect,
    input logic                              insnValid,
    input logic                              insnReady,
    input insn_t                             insn,
    input addr_t                             insnPc,
    input logic                              insnCompressed,
    input logic                              insnFault,
    input logic                              pop1,
    input logic                              pop2,
    input logic                              writeLow,
    input logic                              writeHigh,
    input logic [$clog2(BufferDepth):0]      writableEntryCount
);
    localparam int CountWidth = $clog2(BufferDepth) + 1;

    int failCount = 0;

    // stalled output holds until taken, unless a redirect drops it
    assert property (@(posedge clk) disable iff (!rstN)
        insnValid && !insnReady |=> redirect || (insnValid && $stable(insn)
            && $stable(insnPc) && $stable(insnCompressed) && $stable(insnFault)))
    else begin
        $error("aligner output changed while insnReady was low");
        failCount++;
    end

    // one pop size per cycle
    assert property (@(posedge clk) disable iff (!rstN) !(pop1 && pop2))
    else begin
        $error("pop1 and pop2 high together");
        failCount++;
    end

    // pushes never exceed the free slots
    assert property (@(posedge clk) disable iff (!rstN)
        CountWidth'(writeLow) + CountWidth'(writeHigh) <= writableEntryCount)
    else begin
        $error("buffer written beyond its free count");
        failCount++;
    end

    // redirect silences the output for a cycle
    assert property (@(posedge clk) disable iff (!rstN) redirect |=> !insnValid)
    else begin
        $error("insnValid high in the cycle after a redirect");
        failCount++;
    end

endmodule

bind fetchTop fetchTopProps #(.BufferDepth(BufferDepth)) props (
    .clk                (clk),
    .rstN               (rstN),
    .redirect           (redirect),
    .insnValid          (insnValid),
    .insnReady          (insnReady),
    .insn               (insn),
    .insnPc             (insnPc),
    .insnCompressed     (insnCompressed),
    .insnFault          (insnFault),
    .pop1               (readBus.pop1),
    .pop2               (readBus.pop2),
    .writeLow           (writeBus.writeLow),
    .writeHigh          (writeBus.writeHigh),
    .writableEntryCount (writeBus.writableEntryCount)
);

// File: test/fetchTb.sv
`timescale 1ns/1ps

module fetchTb import fetchPkg::*; ();
    localparam int MemLines = 16;
    localparam int MemHalves = MemLines * 4;
    localparam int MemBytes = MemLines * 8;

    // one table row
    typedef struct packed {
        logic [1:0] kind;
        addr_t      startPc;
        logic [7:0] count;
        logic [7:0] stallPct;
        logic [7:0] redirectAfter;
        addr_t      redirectPc;
    } row_t;

    typedef struct packed {
        addr_t pc;
        insn_t insn;
        logic  compressed;
        logic  fault;
    } expected_t;

    logic                        clk;
    logic                        rstN;
    logic                        memWe;
    logic [$clog2(MemLines)-1:0] memAddr;
    line_t                       memData;
    logic                        redirect;
    addr_t                       redirectPc;
    logic                        insnValid;
    logic                        insnReady;
    insn_t                       insn;
    addr_t                       insnPc;
    logic                        insnCompressed;
    logic                        insnFault;

    row_t      rows [$];
    string     rowNames [$];
    half_t     image [MemHalves];
    expected_t expQ [$];
    int        errors = 0;
    int        checked = 0;
    int        cycles = 0;
    int        cycleLimit = 0;

    clockGen clocks (.clk(clk), .rstN(rstN));

    fetchTop #(.MemLines(MemLines)) dut (.*);

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            $display("timeout: stream stalled, limit of %0d cycles reached", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic addRow(input string name, input int kind, input int startPc,
                          input int count, input int stallPct, input int after,
                          input int newPc);
        rows.push_back('{kind[1:0], addr_t'(startPc), count[7:0], stallPct[7:0],
                         after[7:0], addr_t'(newPc)});
        rowNames.push_back(name);
    endtask

    // kind 0 all full, kind 1 compressed and full interleaved, kind 2 random
    task automatic buildProgram(input logic [1:0] kind);
        insn_t word;
        for (int i = 0; i < MemHalves; i++) begin
            word = (insn_t'(i / 2) << 12) | 32'h0000_0093;
            if (kind == 2'd0) begin
                image[i] = i[0] ? word[31:16] : word[15:0];
            end else if (kind == 2'd1) begin
                // groups of three, so full ones land across line edges
                if (i % 3 == 0) begin
                    image[i] = half_t'(i << 2) | 16'h0001;
                end else if (i % 3 == 1) begin
                    image[i] = half_t'(i << 2) | 16'h0003;
                end else begin
                    image[i] = 16'hA000 | half_t'(i);
                end
            end else begin
                image[i] = half_t'($urandom);
            end
        end
    endtask

    // walk the halfword image by the low-two-bits rule
    task automatic expectStream(input addr_t startPc, input int n);
        addr_t pc;
        half_t lo;
        half_t hi;
        pc = startPc;
        repeat (n) begin
            if (pc >= addr_t'(MemBytes)) begin
                expQ.push_back('{pc, insn_t'(0), 1'b1, 1'b1});
                pc = pc + 2;
            end else begin
                lo = image[pc >> 1];
                if (lo[1:0] != 2'b11) begin
                    expQ.push_back('{pc, insn_t'(lo), 1'b1, 1'b0});
                    pc = pc + 2;
                end else begin
                    hi = (pc + 2 < addr_t'(MemBytes)) ? image[(pc >> 1) + 1] : '0;
                    expQ.push_back('{pc, {hi, lo}, 1'b0, 1'b0});
                    pc = pc + 4;
                end
            end
        end
    endtask

    task automatic compareValue(input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %h, actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    // redirect held for the whole load, memory written one line per cycle
    task automatic loadAndStart(input addr_t startPc);
        @(negedge clk);
        redirect = 1'b1;
        redirectPc = startPc;
        insnReady = 1'b0;
        for (int l = 0; l < MemLines; l++) begin
            memWe = 1'b1;
            memAddr = l[$clog2(MemLines)-1:0];
            memData = {image[4*l+3], image[4*l+2], image[4*l+1], image[4*l]};
            @(negedge clk);
        end
        memWe = 1'b0;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    task automatic pulseRedirect(input addr_t newPc);
        @(negedge clk);
        redirect = 1'b1;
        redirectPc = newPc;
        insnReady = 1'b0;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    // outputs are settled at the falling edge, taken at the next rising one
    task automatic acceptInsns(input string name, input int n, input int stallPct);
        int got;
        logic take;
        expected_t exp;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            take = $urandom_range(99) >= stallPct;
            insnReady = take;
            if (insnValid && take) begin
                exp = expQ.pop_front();
                compareValue(name, "pc", exp.pc, insnPc);
                compareValue(name, "insn", exp.insn, insn);
                compareValue(name, "compressed", 32'(exp.compressed), 32'(insnCompressed));
                compareValue(name, "fault", 32'(exp.fault), 32'(insnFault));
                checked++;
                got++;
            end
        end
    endtask

    initial begin
        row_t row;
        void'($urandom(46561));
        memWe = 1'b0;
        memAddr = '0;
        memData = '0;
        redirect = 1'b1;
        redirectPc = '0;
        insnReady = 1'b0;

        addRow("fullSeq", 0, 0, 14, 0, 0, 0);
        addRow("mixedWidths", 1, 0, 24, 0, 0, 0);
        addRow("upperStart2", 1, 2, 10, 0, 0, 0);
        addRow("upperStart6", 0, 6, 8, 0, 0, 0);
        addRow("mixedStall", 1, 0, 24, 50, 0, 0);
        addRow("randomStall", 2, 0, 30, 50, 0, 0);
        addRow("midRedirect", 1, 0, 16, 25, 6, 40);
        addRow("endOfMemory", 0, 112, 8, 0, 0, 0);

        cycleLimit = 10;
        foreach (rows[r]) begin
            cycleLimit += 20 * int'(rows[r].count) + 50;
        end

        @(posedge rstN);
        foreach (rows[r]) begin
            row = rows[r];
            buildProgram(row.kind);
            expQ.delete();
            if (row.redirectAfter != 0) begin
                expectStream(row.startPc, int'(row.redirectAfter));
                expectStream(row.redirectPc, int'(row.count) - int'(row.redirectAfter));
                loadAndStart(row.startPc);
                acceptInsns(rowNames[r], int'(row.redirectAfter), int'(row.stallPct));
                pulseRedirect(row.redirectPc);
                acceptInsns(rowNames[r], int'(row.count) - int'(row.redirectAfter),
                            int'(row.stallPct));
            end else begin
                expectStream(row.startPc, int'(row.count));
                loadAndStart(row.startPc);
                acceptInsns(rowNames[r], int'(row.count), int'(row.stallPct));
            end
        end

        $display("instructions checked %0d, value errors %0d, assertion failures %0d",
                 checked, errors, dut.props.failCount);
        if (errors == 0 && dut.props.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: all.f
logic/fetchPkg.sv
logic/fetchUnitIf.sv
logic/insnBufferIf.sv
logic/fetchUnit.sv
logic/fetchStage.sv
logic/insnBuffer.sv
logic/insnAligner.sv
logic/fetchTop.sv
test/clockGen.sv
test/fetchTop_props.sv
test/fetchTb.sv

// File: run.sh
#!/bin/sh
# compile the front end with its testbench, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module fetchTb -o fetchSim \
    && ./obj_dir/fetchSim +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
